// ==== Bender.yml ====
package:
  name: blob_tracker

sources:
  - hw/tracker_pkg.sv
  - hw/video_timing.sv
  - hw/chroma_threshold.sv
  - hw/seq_divider.sv
  - hw/centroid_accum.sv
  - hw/overlay_mux.sv
  - hw/blob_tracker_top.sv
  - target: test
    files:
      - dv/blob_tracker_sva.sv
      - dv/blob_tracker_tb.sv

// ==== blob_tracker.f ====
hw/tracker_pkg.sv
hw/video_timing.sv
hw/chroma_threshold.sv
hw/seq_divider.sv
hw/centroid_accum.sv
hw/overlay_mux.sv
hw/blob_tracker_top.sv
dv/blob_tracker_sva.sv
dv/blob_tracker_tb.sv

// ==== dv/blob_tracker_sva.sv ====
`default_nettype none

module blob_tracker_sva (
    input wire                     clk_pixel,
    input wire                     sys_rst_pixel,
    input wire tracker_pkg::scan_t scan,
    input wire tracker_pkg::scan_t video_out,
    input wire tracker_pkg::com_t  com
);

    timeunit 1ns;
    timeprecision 1ps;

    // frame marker only at the origin
    frame_pulse: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        scan.new_frame |=> !scan.new_frame)
        else $error("new_frame stayed high for more than one cycle");

    com_pulse: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        com.valid |=> !com.valid)
        else $error("com valid stayed high for more than one cycle");

    // two register stages from raster to output
    out_delay: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        video_out == $past(scan, 2))
        else $error("video_out is not scan delayed by two cycles");

endmodule

`default_nettype wire

// ==== dv/blob_tracker_tb.sv ====
`default_nettype none

module blob_tracker_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int H_ACT = 24;
    localparam int V_ACT = 12;
    localparam int BLANK = 2;
    localparam int SUM_W = 16;
    localparam int H_TOT = H_ACT + 3 * BLANK;
    localparam int V_TOT = V_ACT + 3 * BLANK;
    // eight frames of raster plus reset and slack
    localparam int CYCLE_LIMIT = 8 * H_TOT * V_TOT + 200;
    // window edges, the rectangle uses both plus the middle
    localparam logic [7:0] CB_LO = 8'hA0;
    localparam logic [7:0] CB_HI = 8'hC0;

    // one expected output beat
    typedef struct packed {
        tracker_pkg::scan_t video;
        tracker_pkg::rgb_t  pixel;
    } expect_t;

    logic                  clk_pixel = 1'b0;
    logic                  sys_rst_pixel;
    tracker_pkg::ycc_t     pixel_in;
    logic [7:0]            lower_bound;
    logic [7:0]            upper_bound;
    tracker_pkg::bg_mode_t bg_mode;
    logic                  cross_enable;
    tracker_pkg::scan_t    scan;
    tracker_pkg::scan_t    video_out;
    tracker_pkg::rgb_t     pixel_out;
    tracker_pkg::com_t     com;

    // rectangle corners, drawn from the lcg
    int rect_x0;
    int rect_x1;
    int rect_y0;
    int rect_y1;
    int cycle_count = 0;
    int pulse_count = 0;

    // reference model state
    expect_t               out_q[$];
    int                    h_pos = 0;
    int                    v_pos = 0;
    int                    sum_x = 0;
    int                    sum_y = 0;
    int                    pix_cnt = 0;
    int                    cmp_cycle = 0;
    int                    due_cycle = -1;
    int                    due_x = 0;
    int                    due_y = 0;
    int                    cen_x = 0;
    int                    cen_y = 0;
    logic                  have_cen = 1'b0;
    // inputs as the DUT sampled them
    logic                  in_rst;
    logic [7:0]            in_lo;
    logic [7:0]            in_hi;
    tracker_pkg::bg_mode_t in_mode;
    logic                  in_cross;

    blob_tracker_top #(
        .H_ACTIVE(H_ACT),
        .H_FRONT (BLANK),
        .H_SYNC  (BLANK),
        .H_BACK  (BLANK),
        .V_ACTIVE(V_ACT),
        .V_FRONT (BLANK),
        .V_SYNC  (BLANK),
        .V_BACK  (BLANK),
        .SUM_W   (SUM_W)
    ) dut (
        .clk_pixel    (clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .pixel_in     (pixel_in),
        .lower_bound  (lower_bound),
        .upper_bound  (upper_bound),
        .bg_mode      (bg_mode),
        .cross_enable (cross_enable),
        .scan         (scan),
        .video_out    (video_out),
        .pixel_out    (pixel_out),
        .com          (com)
    );

    bind blob_tracker_top blob_tracker_sva u_sva (
        .clk_pixel    (clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .scan         (scan),
        .video_out    (video_out),
        .com          (com)
    );

    always #2 clk_pixel = ~clk_pixel;

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // test image, only the rectangle falls inside the window
    function automatic tracker_pkg::ycc_t image_pixel(input int h, input int v);
        tracker_pkg::ycc_t p;
        int                sel;
        sel  = (h + v) % 3;
        p.y  = 8'(h * 9 + v * 17);
        p.cr = 8'(h ^ v);
        if (h >= rect_x0 && h <= rect_x1 && v >= rect_y0 && v <= rect_y1) begin
            p.cb = CB_LO + 8'(sel * 16);
        end else begin
            // one below, one above the window, then far off
            case (sel)
                0:       p.cb = CB_LO - 8'd1;
                1:       p.cb = CB_HI + 8'd1;
                default: p.cb = 8'h40;
            endcase
        end
        return p;
    endfunction

    function automatic logic in_window(input logic [7:0] cb, input logic [7:0] lo,
                                       input logic [7:0] hi);
        return (cb >= lo) && (cb <= hi);
    endfunction

    function automatic tracker_pkg::scan_t expect_scan(input int h, input int v);
        tracker_pkg::scan_t s;
        s.hcount      = tracker_pkg::COORD_W'(h);
        s.vcount      = tracker_pkg::COORD_W'(v);
        // sync follows the front porch
        s.hsync       = (h >= H_ACT + BLANK) && (h < H_ACT + 2 * BLANK);
        s.vsync       = (v >= V_ACT + BLANK) && (v < V_ACT + 2 * BLANK);
        s.active_draw = (h < H_ACT) && (v < V_ACT);
        s.new_frame   = (h == 0) && (v == 0);
        return s;
    endfunction

    function automatic tracker_pkg::rgb_t expect_pixel(input tracker_pkg::scan_t s,
                                                       input tracker_pkg::ycc_t p,
                                                       input logic hit,
                                                       input tracker_pkg::bg_mode_t mode,
                                                       input logic cross_on,
                                                       input int cx, input int cy);
        tracker_pkg::rgb_t grey;
        grey = {p.y, p.y, p.y};
        if (!s.active_draw) begin
            return 24'h00_00_00;
        end
        if (cross_on && (s.hcount == cx || s.vcount == cy)) begin
            return 24'hFF_FF_FF;
        end
        case (mode)
            tracker_pkg::BG_MASK:    return hit ? 24'hFF_FF_FF : 24'h00_00_00;
            tracker_pkg::BG_MAGENTA: return hit ? {8'hFF, p.y, 8'hFF} : grey;
            default:                 return grey;
        endcase
    endfunction

    function automatic int floor_mean(input int sum, input int count);
        return sum / count;
    endfunction

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // stops on the second line of vertical blanking
    task automatic wait_vblank();
        do begin
            @(negedge clk_pixel);
        end while (!(scan.vcount == V_ACT + 1 && scan.hcount == 0));
    endtask

    always @(negedge clk_pixel) begin
        pixel_in = image_pixel(scan.hcount, scan.vcount);
    end

    always @(posedge clk_pixel) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout, run still going after %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    always begin : compare_outputs
        tracker_pkg::ycc_t  pix;
        tracker_pkg::scan_t want;
        expect_t            front;
        logic               hit;
        @(posedge clk_pixel);
        in_rst   = sys_rst_pixel;
        in_lo    = lower_bound;
        in_hi    = upper_bound;
        in_mode  = bg_mode;
        in_cross = cross_enable;
        @(negedge clk_pixel);
        if (!in_rst) begin
            cmp_cycle++;
            want = expect_scan(h_pos, v_pos);
            compare_word("raster", want, scan);
            h_pos = (h_pos == H_TOT - 1) ? 0 : h_pos + 1;
            if (h_pos == 0) begin
                v_pos = (v_pos == V_TOT - 1) ? 0 : v_pos + 1;
            end
            // pulse lands sum_w+1 after stage-1 new_frame
            compare_word("com_valid", cmp_cycle == due_cycle, com.valid);
            if (cmp_cycle == due_cycle) begin
                cen_x    = due_x;
                cen_y    = due_y;
                have_cen = 1'b1;
            end
            // pulses as the DUT really gave them
            if (com.valid) begin
                pulse_count++;
            end
            compare_word("com_x", cen_x, com.x);
            compare_word("com_y", cen_y, com.y);
            pix = image_pixel(want.hcount, want.vcount);
            hit = in_window(pix.cb, in_lo, in_hi) && want.active_draw;
            // origin closes the frame and opens the next
            if (want.new_frame) begin
                if (pix_cnt != 0) begin
                    due_cycle = cmp_cycle + SUM_W + 2;
                    due_x     = floor_mean(sum_x, pix_cnt);
                    due_y     = floor_mean(sum_y, pix_cnt);
                end
                sum_x   = 0;
                sum_y   = 0;
                pix_cnt = 0;
            end
            if (hit) begin
                sum_x += want.hcount;
                sum_y += want.vcount;
                pix_cnt++;
            end
            front = out_q.pop_front();
            compare_word("video_out", front.video, video_out);
            compare_word("pixel_out", front.pixel, pixel_out);
            out_q.push_back('{video: want,
                              pixel: expect_pixel(want, pix, hit, in_mode,
                                                  in_cross && have_cen, cen_x, cen_y)});
        end
    end

    initial begin : drive_stimulus
        int unsigned seed;
        seed = 94;
        seed = lcg_next(seed);
        rect_x0 = 1 + int'((seed >> 16) % 8);
        seed = lcg_next(seed);
        rect_x1 = rect_x0 + 4 + int'((seed >> 16) % 8);
        seed = lcg_next(seed);
        rect_y0 = 1 + int'((seed >> 16) % 4);
        seed = lcg_next(seed);
        rect_y1 = rect_y0 + 2 + int'((seed >> 16) % 4);
        sys_rst_pixel = 1'b1;
        pixel_in      = '0;
        lower_bound   = CB_LO;
        upper_bound   = CB_HI;
        bg_mode       = tracker_pkg::BG_GREY;
        cross_enable  = 1'b0;
        // two beats still in flight from reset
        out_q.push_back('0);
        out_q.push_back('0);
        repeat (10) @(posedge clk_pixel);
        @(negedge clk_pixel);
        compare_word("reset_scan", 0, scan);
        compare_word("reset_video_out", 0, video_out);
        compare_word("reset_pixel_out", 0, pixel_out);
        compare_word("reset_com", 0, com);
        sys_rst_pixel = 1'b0;
        // no centre yet, so the crosshair stays hidden
        cross_enable  = 1'b1;
        // frame 1 grey, then mask, then magenta
        wait_vblank();
        bg_mode      = tracker_pkg::BG_MASK;
        cross_enable = 1'b0;
        wait_vblank();
        bg_mode = tracker_pkg::BG_MAGENTA;
        // centre known since frame 2
        wait_vblank();
        bg_mode      = tracker_pkg::BG_RESERVED;
        cross_enable = 1'b1;
        wait_vblank();
        bg_mode = tracker_pkg::BG_MAGENTA;
        // window above every cb value, frame 6 stays empty
        wait_vblank();
        cross_enable = 1'b0;
        lower_bound  = 8'hD0;
        upper_bound  = 8'hFF;
        wait_vblank();
        wait_vblank();
        // frames 1 to 5 each close with hits
        compare_word("com_pulses", 5, pulse_count);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/blob_tracker_top.sv ====
`default_nettype none

module blob_tracker_top #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT  = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BACK   = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT  = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BACK   = 20,
    parameter int SUM_W    = 32
) (
    input  wire                            clk_pixel,
    input  wire                            sys_rst_pixel,
    input  wire tracker_pkg::ycc_t         pixel_in,
    input  wire [tracker_pkg::CHAN_W-1:0]  lower_bound,
    input  wire [tracker_pkg::CHAN_W-1:0]  upper_bound,
    input  wire tracker_pkg::bg_mode_t     bg_mode,
    input  wire                            cross_enable,
    output tracker_pkg::scan_t             scan,
    output tracker_pkg::scan_t             video_out,
    output tracker_pkg::rgb_t              pixel_out,
    output tracker_pkg::com_t              com
);

    // stage 1
    tracker_pkg::scan_t scan_s1;
    tracker_pkg::ycc_t  pixel_s1;
    logic               mask;

    // stage 0 raster
    video_timing #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT (H_FRONT),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT (V_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK)
    ) u_timing (
        .clk_pixel    (clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .scan         (scan)
    );

    chroma_threshold u_thresh (
        .clk_pixel    (clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .scan_in      (scan),
        .pixel_in     (pixel_in),
        .lower_bound  (lower_bound),
        .upper_bound  (upper_bound),
        .scan_s1      (scan_s1),
        .pixel_s1     (pixel_s1),
        .mask         (mask)
    );

    // per-frame centre of mass
    centroid_accum #(
        .SUM_W(SUM_W)
    ) u_centroid (
        .clk_pixel    (clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .scan_s1      (scan_s1),
        .mask         (mask),
        .com          (com)
    );

    // stage 2 output
    overlay_mux u_overlay (
        .clk_pixel    (clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .scan_s1      (scan_s1),
        .pixel_s1     (pixel_s1),
        .mask         (mask),
        .com          (com),
        .bg_mode      (bg_mode),
        .cross_enable (cross_enable),
        .video_out    (video_out),
        .pixel_out    (pixel_out)
    );

endmodule

`default_nettype wire

// ==== hw/centroid_accum.sv ====
`default_nettype none

module centroid_accum #(
    parameter int SUM_W = 32
) (
    input  wire                      clk_pixel,
    input  wire                      sys_rst_pixel,
    input  wire tracker_pkg::scan_t  scan_s1,
    input  wire                      mask,
    output tracker_pkg::com_t        com
);

    logic [SUM_W-1:0] sum_x;
    logic [SUM_W-1:0] sum_y;
    logic [SUM_W-1:0] pix_count;

    logic             div_start;
    logic [SUM_W-1:0] quot_x;
    logic [SUM_W-1:0] quot_y;
    logic             done_x;
    logic             done_y;

    // skip empty frames so the divisor is never zero
    assign div_start = scan_s1.new_frame && (pix_count != '0);

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            sum_x     <= '0;
            sum_y     <= '0;
            pix_count <= '0;
        end else if (scan_s1.new_frame) begin
            // origin pixel opens the next frame
            sum_x     <= mask ? SUM_W'(scan_s1.hcount) : '0;
            sum_y     <= mask ? SUM_W'(scan_s1.vcount) : '0;
            pix_count <= mask ? SUM_W'(1) : '0;
        end else if (mask) begin
            sum_x     <= sum_x + SUM_W'(scan_s1.hcount);
            sum_y     <= sum_y + SUM_W'(scan_s1.vcount);
            pix_count <= pix_count + 1'b1;
        end
    end

    // mean column
    seq_divider #(
        .SUM_W(SUM_W)
    ) div_x (
        .clk_pixel    (clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .start        (div_start),
        .dividend     (sum_x),
        .divisor      (pix_count),
        .quotient     (quot_x),
        .done         (done_x)
    );

    // mean row
    seq_divider #(
        .SUM_W(SUM_W)
    ) div_y (
        .clk_pixel    (clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .start        (div_start),
        .dividend     (sum_y),
        .divisor      (pix_count),
        .quotient     (quot_y),
        .done         (done_y)
    );

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            com <= '0;
        end else begin
            com.valid <= done_x && done_y;
            // both start together, so done lines up
            if (done_x && done_y) begin
                com.x <= quot_x[tracker_pkg::COORD_W-1:0];
                com.y <= quot_y[tracker_pkg::COORD_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/chroma_threshold.sv ====
`default_nettype none

module chroma_threshold (
    input  wire                              clk_pixel,
    input  wire                              sys_rst_pixel,
    input  wire tracker_pkg::scan_t          scan_in,
    input  wire tracker_pkg::ycc_t           pixel_in,
    input  wire [tracker_pkg::CHAN_W-1:0]    lower_bound,
    input  wire [tracker_pkg::CHAN_W-1:0]    upper_bound,
    output tracker_pkg::scan_t               scan_s1,
    output tracker_pkg::ycc_t                pixel_s1,
    output logic                             mask
);

    // inclusive window on cb
    logic in_window;

    assign in_window = (pixel_in.cb >= lower_bound) && (pixel_in.cb <= upper_bound);

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            scan_s1 <= '0;
            mask    <= 1'b0;
        end else begin
            scan_s1 <= scan_in;
            // blanking never counts as a hit
            mask    <= in_window && scan_in.active_draw;
        end
    end

    // pixel rides along with its mask
    always_ff @(posedge clk_pixel) begin
        pixel_s1 <= pixel_in;
    end

endmodule

`default_nettype wire

// ==== hw/overlay_mux.sv ====
`default_nettype none

module overlay_mux (
    input  wire                          clk_pixel,
    input  wire                          sys_rst_pixel,
    input  wire tracker_pkg::scan_t      scan_s1,
    input  wire tracker_pkg::ycc_t       pixel_s1,
    input  wire                          mask,
    input  wire tracker_pkg::com_t       com,
    input  wire tracker_pkg::bg_mode_t   bg_mode,
    input  wire                          cross_enable,
    output tracker_pkg::scan_t           video_out,
    output tracker_pkg::rgb_t            pixel_out
);

    // last centre seen and whether one exists yet
    logic [tracker_pkg::COORD_W-1:0] cx;
    logic [tracker_pkg::COORD_W-1:0] cy;
    logic                            have_com;

    tracker_pkg::rgb_t grey;
    tracker_pkg::rgb_t bg;
    tracker_pkg::rgb_t pix_nxt;
    logic              on_cross;

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            cx       <= '0;
            cy       <= '0;
            have_com <= 1'b0;
        end else if (com.valid) begin
            cx       <= com.x;
            cy       <= com.y;
            have_com <= 1'b1;
        end
    end

    always_comb begin
        grey = '{red: pixel_s1.y, green: pixel_s1.y, blue: pixel_s1.y};
        case (bg_mode)
            tracker_pkg::BG_MASK:    bg = mask ? '1 : '0;
            // magenta keeps luma on green
            tracker_pkg::BG_MAGENTA: bg = mask ? '{red: '1, green: pixel_s1.y, blue: '1} : grey;
            default:                 bg = grey;
        endcase
        on_cross = cross_enable && have_com &&
                   ((scan_s1.hcount == cx) || (scan_s1.vcount == cy));
        if (!scan_s1.active_draw) begin
            pix_nxt = '0;
        end else if (on_cross) begin
            pix_nxt = tracker_pkg::CROSS_COLOR;
        end else begin
            pix_nxt = bg;
        end
    end

    // stage 2, scan and pixel stay together
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            video_out <= '0;
            pixel_out <= '0;
        end else begin
            video_out <= scan_s1;
            pixel_out <= pix_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== hw/seq_divider.sv ====
`default_nettype none

module seq_divider #(
    parameter int SUM_W = 32
) (
    input  wire              clk_pixel,
    input  wire              sys_rst_pixel,
    input  wire              start,
    input  wire  [SUM_W-1:0] dividend,
    input  wire  [SUM_W-1:0] divisor,
    output logic [SUM_W-1:0] quotient,
    output logic             done
);

    localparam int CNT_W = $clog2(SUM_W + 1);

    logic [SUM_W-1:0] rem;
    // dividend shifts out the top while quotient bits shift in
    logic [SUM_W-1:0] dq;
    logic [SUM_W-1:0] div_q;
    logic [CNT_W-1:0] step_cnt;
    logic             busy;

    logic [SUM_W-1:0] src_rem;
    logic [SUM_W-1:0] src_dq;
    logic [SUM_W-1:0] src_div;
    logic [SUM_W:0]   trial;
    logic [SUM_W:0]   diff;
    logic             fits;
    logic [SUM_W-1:0] rem_nxt;
    logic [SUM_W-1:0] dq_nxt;

    // first step runs straight off the inputs on start
    always_comb begin
        src_rem = start ? '0 : rem;
        src_dq  = start ? dividend : dq;
        src_div = start ? divisor : div_q;
        trial   = {src_rem, src_dq[SUM_W-1]};
        diff    = trial - {1'b0, src_div};
        fits    = (trial >= {1'b0, src_div});
        // restore by keeping the trial when it does not fit
        rem_nxt = fits ? diff[SUM_W-1:0] : trial[SUM_W-1:0];
        dq_nxt  = {src_dq[SUM_W-2:0], fits};
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            step_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                // restart even when busy
                busy     <= 1'b1;
                step_cnt <= CNT_W'(1);
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == CNT_W'(SUM_W - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk_pixel) begin
        if (start || busy) begin
            rem <= rem_nxt;
            dq  <= dq_nxt;
        end
        if (start) begin
            div_q <= divisor;
        end
        // final quotient held until the next run ends
        if (busy && !start && step_cnt == CNT_W'(SUM_W - 1)) begin
            quotient <= dq_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== hw/tracker_pkg.sv ====
`default_nettype none

package tracker_pkg;

    // one colour or chroma channel
    localparam int CHAN_W = 8;
    // enough for 1280 columns
    localparam int COORD_W = 11;

    // camera pixel as delivered, luma first
    typedef struct packed {
        logic [CHAN_W-1:0] y;
        logic [CHAN_W-1:0] cb;
        logic [CHAN_W-1:0] cr;
    } ycc_t;

    // display pixel
    typedef struct packed {
        logic [CHAN_W-1:0] red;
        logic [CHAN_W-1:0] green;
        logic [CHAN_W-1:0] blue;
    } rgb_t;

    // one raster position plus its timing flags
    typedef struct packed {
        logic [COORD_W-1:0] hcount;
        logic [COORD_W-1:0] vcount;
        logic               hsync;
        logic               vsync;
        logic               active_draw;
        logic               new_frame;
    } scan_t;

    // centre of mass, valid is a one-cycle pulse
    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        logic               valid;
    } com_t;

    // background choice
    typedef enum logic [1:0] {
        BG_GREY     = 2'b00,
        BG_MASK     = 2'b01,
        BG_MAGENTA  = 2'b10,
        BG_RESERVED = 2'b11
    } bg_mode_t;

    // crosshair is plain white
    localparam logic [3*CHAN_W-1:0] CROSS_COLOR = 24'hFF_FF_FF;

endpackage

`default_nettype wire

// ==== hw/video_timing.sv ====
`default_nettype none

module video_timing #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT  = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BACK   = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT  = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BACK   = 20
) (
    input  wire                clk_pixel,
    input  wire                sys_rst_pixel,
    output tracker_pkg::scan_t scan
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // position to be emitted at the next edge
    logic [tracker_pkg::COORD_W-1:0] h_cnt;
    logic [tracker_pkg::COORD_W-1:0] v_cnt;

    logic h_last;
    logic v_last;

    assign h_last = (h_cnt == tracker_pkg::COORD_W'(H_TOTAL - 1));
    assign v_last = (v_cnt == tracker_pkg::COORD_W'(V_TOTAL - 1));

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            h_cnt <= '0;
            v_cnt <= '0;
            scan  <= '0;
        end else begin
            // decode flags for the current position
            scan.hcount      <= h_cnt;
            scan.vcount      <= v_cnt;
            // sync sits right after the front porch
            scan.hsync       <= (h_cnt >= tracker_pkg::COORD_W'(H_ACTIVE + H_FRONT)) &&
                                (h_cnt < tracker_pkg::COORD_W'(H_ACTIVE + H_FRONT + H_SYNC));
            scan.vsync       <= (v_cnt >= tracker_pkg::COORD_W'(V_ACTIVE + V_FRONT)) &&
                                (v_cnt < tracker_pkg::COORD_W'(V_ACTIVE + V_FRONT + V_SYNC));
            scan.active_draw <= (h_cnt < tracker_pkg::COORD_W'(H_ACTIVE)) &&
                                (v_cnt < tracker_pkg::COORD_W'(V_ACTIVE));
            // both counters at origin
            scan.new_frame   <= (h_cnt == '0) && (v_cnt == '0);

            // step the raster
            if (h_last) begin
                h_cnt <= '0;
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
